// ==== pcs_pkg.sv ====
`default_nettype none

package pcs_pkg;

    // Widths fixed by the 64b/66b line code
    typedef logic [31:0] xgmii_data_t;      // One XGMII word, four byte lanes
    typedef logic [3:0]  xgmii_ctrl_t;      // One control bit per lane
    typedef logic [1:0]  sync_hdr_t;        // 66b sync header
    typedef logic [7:0]  block_type_t;      // Block type field of a control block

    // Block type field values
    localparam block_type_t BT_IDLE  = 8'h1E;   // All control and error code blocks
    localparam block_type_t BT_START = 8'h78;   // Start in lane 0
    localparam block_type_t BT_TERM0 = 8'h87;
    localparam block_type_t BT_TERM1 = 8'h99;
    localparam block_type_t BT_TERM2 = 8'hAA;
    localparam block_type_t BT_TERM3 = 8'hB4;
    localparam block_type_t BT_TERM4 = 8'hCC;
    localparam block_type_t BT_TERM5 = 8'hD2;
    localparam block_type_t BT_TERM6 = 8'hE1;
    localparam block_type_t BT_TERM7 = 8'hFF;

    // XGMII control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM  = 8'hFD;
    localparam logic [7:0] XGMII_ERROR = 8'hFE;

    // Sync headers
    localparam sync_hdr_t HDR_DATA = 2'b01;
    localparam sync_hdr_t HDR_CTRL = 2'b10;

    // 7-bit PCS control codes
    localparam logic [6:0] PCS_IDLE  = 7'h00;
    localparam logic [6:0] PCS_ERROR = 7'h1E;

    // Default scrambler state, all ones
    localparam logic [57:0] SCR_SEED_DEFAULT = {58{1'b1}};

    // Half of a 66b block between stages
    typedef struct packed {
        logic        valid;     // Half present
        logic        first;     // Low 32 bits of the block
        sync_hdr_t   hdr;       // Only meaningful with first
        xgmii_data_t data;
    } enc_half_t;

endpackage

`default_nettype wire

// ==== xgmii_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module xgmii_encoder import pcs_pkg::*; (
    input  wire         gty_tx_usr_clk,
    input  wire         i_arst_n,
    input  xgmii_data_t i_xgmii_txd,
    input  xgmii_ctrl_t i_xgmii_txc,
    input  wire         i_xgmii_valid,
    input  wire         i_rx_trdy,          // Ready level from the gearbox
    output logic        o_xgmii_pause,
    output enc_half_t   o_tx_half,
    output logic        o_tx_encoding_err
);

    typedef enum logic {
        LOW_WORD,
        HIGH_WORD
    } word_state_e;

    word_state_e  state_q;
    xgmii_data_t  lo_txd_q;                 // First word of the pair
    xgmii_ctrl_t  lo_txc_q;
    xgmii_data_t  hi_data_q;                // Upper half of the block in flight
    logic         hi_pend_q;
    logic         accept;
    logic [63:0]  pair_txd;
    logic [7:0]   pair_txc;
    logic [7:0]   term_match;               // One bit per terminate position
    logic         code_ok;                  // Pair is all idle or error characters
    logic         term_hit;
    sync_hdr_t    blk_hdr;
    logic [63:0]  blk_data;
    logic         blk_err;

    // Type byte of a terminate at lane k
    function automatic block_type_t term_type(input int k);
        case (k)
            0:       return BT_TERM0;
            1:       return BT_TERM1;
            2:       return BT_TERM2;
            3:       return BT_TERM3;
            4:       return BT_TERM4;
            5:       return BT_TERM5;
            6:       return BT_TERM6;
            default: return BT_TERM7;
        endcase
    endfunction

    assign accept        = i_xgmii_valid && i_rx_trdy;   // Input ignored while paused
    assign o_xgmii_pause = ~i_rx_trdy;
    assign pair_txd      = {i_xgmii_txd, lo_txd_q};      // Lanes 7..0
    assign pair_txc      = {i_xgmii_txc, lo_txc_q};

    // Pattern checks over the eight lanes
    always_comb begin
        code_ok = (pair_txc == 8'hFF);
        for (int j = 0; j < 8; j++) begin
            if (pair_txd[8*j +: 8] != XGMII_IDLE && pair_txd[8*j +: 8] != XGMII_ERROR)
                code_ok = 1'b0;
        end
        for (int k = 0; k < 8; k++) begin
            // Control from lane k up with terminate at k
            term_match[k] = (pair_txc == 8'(8'hFF << k)) &&
                            (pair_txd[8*k +: 8] == XGMII_TERM);
            for (int j = k + 1; j < 8; j++) begin
                if (pair_txd[8*j +: 8] != XGMII_IDLE)
                    term_match[k] = 1'b0;   // Only idles may follow
            end
        end
    end

    // Block build
    always_comb begin
        blk_hdr  = HDR_CTRL;
        blk_data = '0;
        blk_err  = 1'b0;
        term_hit = 1'b0;
        if (pair_txc == 8'h00) begin
            blk_hdr  = HDR_DATA;            // Bytes unchanged
            blk_data = pair_txd;
        end else if (pair_txc == 8'h01 && pair_txd[7:0] == XGMII_START) begin
            blk_data = {pair_txd[63:8], BT_START};
        end else if (code_ok) begin
            blk_data[7:0] = BT_IDLE;
            for (int j = 0; j < 8; j++) begin
                // Code Cj sits at bit 7j+8
                blk_data[7*j+8 +: 7] = (pair_txd[8*j +: 8] == XGMII_ERROR) ? PCS_ERROR
                                                                          : PCS_IDLE;
            end
        end else begin
            for (int k = 0; k < 8; k++) begin
                if (term_match[k]) begin
                    term_hit      = 1'b1;
                    blk_data[7:0] = term_type(k);
                    for (int j = 0; j < 8; j++) begin
                        if (j < k)
                            blk_data[8*j+8 +: 8] = pair_txd[8*j +: 8];  // D0..Dk-1
                        else if (j > k)
                            blk_data[7*j+8 +: 7] = PCS_IDLE;
                    end
                end
            end
            if (!term_hit) begin
                blk_err       = 1'b1;       // Unsupported pattern gets an error block
                blk_data[7:0] = BT_IDLE;
                for (int j = 0; j < 8; j++)
                    blk_data[7*j+8 +: 7] = PCS_ERROR;
            end
        end
    end

    // Pair capture and upper half holding
    always_ff @(posedge gty_tx_usr_clk) begin
        if (accept && state_q == LOW_WORD) begin
            lo_txd_q <= i_xgmii_txd;
            lo_txc_q <= i_xgmii_txc;
        end
        if (accept && state_q == HIGH_WORD)
            hi_data_q <= blk_data[63:32];
    end

    always_ff @(posedge gty_tx_usr_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q           <= LOW_WORD;
            hi_pend_q         <= 1'b0;
            o_tx_half         <= '0;
            o_tx_encoding_err <= 1'b0;
        end else begin
            o_tx_encoding_err <= 1'b0;      // Single cycle pulse
            if (i_rx_trdy) begin
                if (accept)
                    state_q <= (state_q == LOW_WORD) ? HIGH_WORD : LOW_WORD;
                if (accept && state_q == HIGH_WORD) begin
                    o_tx_half.valid   <= 1'b1;  // First half one cycle after the pair
                    o_tx_half.first   <= 1'b1;
                    o_tx_half.hdr     <= blk_hdr;
                    o_tx_half.data    <= blk_data[31:0];
                    hi_pend_q         <= 1'b1;
                    o_tx_encoding_err <= blk_err;
                end else if (hi_pend_q) begin
                    o_tx_half.valid <= 1'b1;    // Second half
                    o_tx_half.first <= 1'b0;
                    o_tx_half.data  <= hi_data_q;
                    hi_pend_q       <= 1'b0;
                end else begin
                    o_tx_half.valid <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== scrambler.sv ====
`timescale 1ns/1ps
`default_nettype none

module scrambler import pcs_pkg::*; #(
    parameter logic [57:0] SEED = SCR_SEED_DEFAULT
) (
    input  wire       gty_tx_usr_clk,
    input  wire       i_arst_n,
    input  enc_half_t i_rx_half,
    input  wire       i_rx_trdy,            // Stage advances only when high
    output enc_half_t o_tx_half
);

    logic [57:0] scr_q;                     // Last 58 scrambled bits, newest at bit 0
    logic [57:0] scr_next;
    xgmii_data_t scr_data;

    // Polynomial x^58 + x^39 + 1 applied one bit at a time from the LSB
    always_comb begin
        scr_next = scr_q;
        for (int i = 0; i < 32; i++) begin
            scr_data[i] = i_rx_half.data[i] ^ scr_next[38] ^ scr_next[57];
            scr_next    = {scr_next[56:0], scr_data[i]};
        end
    end

    always_ff @(posedge gty_tx_usr_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            scr_q     <= SEED;
            o_tx_half <= '0;
        end else if (i_rx_trdy) begin
            if (i_rx_half.valid) begin
                scr_q           <= scr_next;
                o_tx_half.valid <= 1'b1;
                o_tx_half.first <= i_rx_half.first;     // Passes through with the data
                o_tx_half.hdr   <= i_rx_half.hdr;       // Header stays unscrambled
                o_tx_half.data  <= scr_data;
            end else begin
                o_tx_half.valid <= 1'b0;                // State held over gaps
            end
        end
    end

endmodule

`default_nettype wire

// ==== gearbox.sv ====
`timescale 1ns/1ps
`default_nettype none

module gearbox import pcs_pkg::*; (
    input  wire         gty_tx_usr_clk,
    input  wire         i_arst_n,
    input  enc_half_t   i_rx_half,
    output logic        o_tx_trdy,          // Low one cycle in 33
    output xgmii_data_t o_tx_data,          // Line word, LSB sent first
    output logic        o_tx_valid
);

    logic [97:0] buf_q;                     // Bits waiting, oldest at bit 0
    logic [97:0] buf_rem;
    logic [97:0] buf_next;
    logic [97:0] keep_mask;
    logic [6:0]  fill_q;                    // Valid bits in buf_q
    logic [6:0]  fill_rem;
    logic [6:0]  fill_next;
    logic [5:0]  stall_cnt_q;               // 0..32
    logic        run_q;                     // Set by first accepted half
    logic        accept;
    logic        emit;
    logic [33:0] in_bits;
    logic [5:0]  in_len;

    assign accept    = i_rx_half.valid && o_tx_trdy;
    assign emit      = (fill_q >= 7'd32);       // Full word available
    assign o_tx_trdy = (stall_cnt_q != 6'd32);  // Drain the 32 surplus bits

    always_comb begin
        // Header goes out ahead of data bit 0
        in_bits   = i_rx_half.first ? {i_rx_half.data, i_rx_half.hdr}
                                    : {2'b00, i_rx_half.data};
        in_len    = i_rx_half.first ? 6'd34 : 6'd32;
        buf_rem   = emit ? (buf_q >> 32) : buf_q;
        fill_rem  = emit ? (fill_q - 7'd32) : fill_q;
        keep_mask = ~({98{1'b1}} << fill_rem);  // Clear anything above the fill
        buf_next  = buf_rem & keep_mask;
        fill_next = fill_rem;
        if (accept) begin
            buf_next  = buf_next | ({64'b0, in_bits} << fill_rem);  // Append behind
            fill_next = fill_rem + {1'b0, in_len};
        end
    end

    always_ff @(posedge gty_tx_usr_clk) begin
        buf_q <= buf_next;
    end

    always_ff @(posedge gty_tx_usr_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            fill_q      <= '0;
            stall_cnt_q <= '0;
            run_q       <= 1'b0;
            o_tx_valid  <= 1'b0;
            o_tx_data   <= '0;
        end else begin
            fill_q <= fill_next;
            run_q  <= run_q | accept;
            // Free running once the first half is in
            if (run_q || accept)
                stall_cnt_q <= (stall_cnt_q == 6'd32) ? 6'd0 : stall_cnt_q + 6'd1;
            o_tx_valid <= emit;
            if (emit)
                o_tx_data <= buf_q[31:0];
        end
    end

endmodule

`default_nettype wire

// ==== pcs.sv ====
`timescale 1ns/1ps
`default_nettype none

module pcs import pcs_pkg::*; #(
    parameter logic [57:0] SCR_SEED = SCR_SEED_DEFAULT
) (
    // GTY TX user clock domain
    input  wire         gty_tx_usr_clk,
    input  wire         i_arst_n,

    // From the MAC
    input  xgmii_data_t i_xgmii_txd,
    input  xgmii_ctrl_t i_xgmii_txc,
    input  wire         i_xgmii_valid,
    output logic        o_xgmii_pause,      // MAC holds its word while high

    // To the transceiver
    output xgmii_data_t o_tx_gearbox_data,
    output logic        o_tx_gearbox_valid,
    output logic        o_tx_encoding_err   // Unsupported pattern replaced
);

    enc_half_t enc_half;                    // Encoder to scrambler
    enc_half_t scr_half;                    // Scrambler to gearbox
    logic      gbx_trdy;                    // Gearbox ready, back to both stages

    xgmii_encoder u_encoder (
        .gty_tx_usr_clk    (gty_tx_usr_clk),
        .i_arst_n          (i_arst_n),
        .i_xgmii_txd       (i_xgmii_txd),
        .i_xgmii_txc       (i_xgmii_txc),
        .i_xgmii_valid     (i_xgmii_valid),
        .i_rx_trdy         (gbx_trdy),
        .o_xgmii_pause     (o_xgmii_pause),
        .o_tx_half         (enc_half),
        .o_tx_encoding_err (o_tx_encoding_err)
    );

    scrambler #(
        .SEED (SCR_SEED)
    ) u_scrambler (
        .gty_tx_usr_clk (gty_tx_usr_clk),
        .i_arst_n       (i_arst_n),
        .i_rx_half      (enc_half),
        .i_rx_trdy      (gbx_trdy),
        .o_tx_half      (scr_half)
    );

    // Repacks 66b blocks into the 32-bit line stream
    gearbox u_gearbox (
        .gty_tx_usr_clk (gty_tx_usr_clk),
        .i_arst_n       (i_arst_n),
        .i_rx_half      (scr_half),
        .o_tx_trdy      (gbx_trdy),
        .o_tx_data      (o_tx_gearbox_data),
        .o_tx_valid     (o_tx_gearbox_valid)
    );

endmodule

`default_nettype wire

// ==== tb_pcs.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pcs import pcs_pkg::*; ();

    localparam int TBL_LEN     = 14;
    localparam int REPEATS     = 8;
    localparam int N_PAIRS     = REPEATS * TBL_LEN * 2;     // Every entry plus one filler pair
    localparam int CYCLE_LIMIT = 2 * (N_PAIRS * 2) + 200;
    localparam logic [57:0] SEED = SCR_SEED_DEFAULT;

    // One XGMII pair with its hand-computed block
    typedef struct packed {
        xgmii_data_t txd0;                  // Lanes 3..0
        xgmii_ctrl_t txc0;
        xgmii_data_t txd1;                  // Lanes 7..4
        xgmii_ctrl_t txc1;
        sync_hdr_t   hdr;
        logic [63:0] blk;                   // Unscrambled payload, bit 0 sent first
        logic        err;                   // Error block substituted
    } stim_t;

    typedef struct packed {
        sync_hdr_t   hdr;
        logic [63:0] blk;
    } exp_t;

    logic        gty_tx_usr_clk = 1'b0;
    logic        arst_n;
    xgmii_data_t xgmii_txd;
    xgmii_ctrl_t xgmii_txc;
    logic        xgmii_valid;
    logic        xgmii_pause;
    xgmii_data_t gbx_data;
    logic        gbx_valid;
    logic        enc_err;

    stim_t       tbl [TBL_LEN];
    string       tbl_name [TBL_LEN];
    exp_t        exp_arr [N_PAIRS];         // Expected blocks in send order
    string       exp_name [N_PAIRS];
    int          n_sent = 0;
    integer      seed;

    // Output side model written by the monitor only
    bit          bit_q [$];                 // Line bits, oldest first
    logic [57:0] dscr_q = SEED;             // Descrambler state
    int          n_blocks = 0;
    int          blk_pass = 0;
    int          blk_fail = 0;
    int          n_err_seen = 0;
    int          n_pause = 0;
    int          last_pause = 0;
    int          pause_errs = 0;
    int          valid_drops = 0;
    int          mon_cycle = 0;
    logic        started = 1'b0;
    logic        mon_done = 1'b0;
    int          cycle_cnt = 0;

    always #50 gty_tx_usr_clk = ~gty_tx_usr_clk;   // 100 ns period

    pcs #(
        .SCR_SEED (SEED)
    ) u_pcs (
        .gty_tx_usr_clk     (gty_tx_usr_clk),
        .i_arst_n           (arst_n),
        .i_xgmii_txd        (xgmii_txd),
        .i_xgmii_txc        (xgmii_txc),
        .i_xgmii_valid      (xgmii_valid),
        .o_xgmii_pause      (xgmii_pause),
        .o_tx_gearbox_data  (gbx_data),
        .o_tx_gearbox_valid (gbx_valid),
        .o_tx_encoding_err  (enc_err)
    );

    task automatic set_entry(input int idx, input xgmii_data_t d0, input xgmii_ctrl_t c0,
                             input xgmii_data_t d1, input xgmii_ctrl_t c1,
                             input sync_hdr_t hdr, input logic [63:0] blk,
                             input logic err, input string name);
        tbl[idx]      = '{d0, c0, d1, c1, hdr, blk, err};
        tbl_name[idx] = name;
    endtask

    // Blocks worked out from the 64b/66b rules with all-zero idle codes
    task automatic load_table();
        set_entry(0,  32'h0707_0707, 4'hF, 32'h0707_0707, 4'hF, HDR_CTRL,
                  64'h0000_0000_0000_001E, 1'b0, "idle");
        set_entry(1,  32'h5555_55FB, 4'h1, 32'hD555_5555, 4'h0, HDR_CTRL,
                  64'hD555_5555_5555_5578, 1'b0, "start lane 0");
        set_entry(2,  32'h3322_1100, 4'h0, 32'h7766_5544, 4'h0, HDR_DATA,
                  64'h7766_5544_3322_1100, 1'b0, "data");
        set_entry(3,  32'h0707_07FD, 4'hF, 32'h0707_0707, 4'hF, HDR_CTRL,
                  64'h0000_0000_0000_0087, 1'b0, "terminate lane 0");
        set_entry(4,  32'h0707_FD11, 4'hE, 32'h0707_0707, 4'hF, HDR_CTRL,
                  64'h0000_0000_0000_1199, 1'b0, "terminate lane 1");
        set_entry(5,  32'h07FD_2211, 4'hC, 32'h0707_0707, 4'hF, HDR_CTRL,
                  64'h0000_0000_0022_11AA, 1'b0, "terminate lane 2");
        set_entry(6,  32'hFD33_2211, 4'h8, 32'h0707_0707, 4'hF, HDR_CTRL,
                  64'h0000_0000_3322_11B4, 1'b0, "terminate lane 3");
        set_entry(7,  32'h4433_2211, 4'h0, 32'h0707_07FD, 4'hF, HDR_CTRL,
                  64'h0000_0044_3322_11CC, 1'b0, "terminate lane 4");
        set_entry(8,  32'h4433_2211, 4'h0, 32'h0707_FD55, 4'hE, HDR_CTRL,
                  64'h0000_5544_3322_11D2, 1'b0, "terminate lane 5");
        set_entry(9,  32'h4433_2211, 4'h0, 32'h07FD_6655, 4'hC, HDR_CTRL,
                  64'h0066_5544_3322_11E1, 1'b0, "terminate lane 6");
        set_entry(10, 32'h4433_2211, 4'h0, 32'hFD77_6655, 4'h8, HDR_CTRL,
                  64'h7766_5544_3322_11FF, 1'b0, "terminate lane 7");
        set_entry(11, 32'h0707_07FE, 4'hF, 32'h0707_0707, 4'hF, HDR_CTRL,
                  64'h0000_0000_0000_1E1E, 1'b0, "error code lane 0");
        // Start in lane 1 is not supported and gives eight error codes
        set_entry(12, 32'h3322_FB11, 4'h2, 32'h7766_5544, 4'h0, HDR_CTRL,
                  64'h3C78_F1E3_C78F_1E1E, 1'b1, "start lane 1 replaced");
        set_entry(13, 32'hFFFF_FFFF, 4'h0, 32'h0123_4567, 4'h0, HDR_DATA,
                  64'h0123_4567_FFFF_FFFF, 1'b0, "data ones");
    endtask

    task automatic put_word(input xgmii_data_t d, input xgmii_ctrl_t c);
        @(negedge gty_tx_usr_clk);
        xgmii_txd   = d;
        xgmii_txc   = c;
        xgmii_valid = 1'b1;
        while (xgmii_pause)                 // MAC holds the word through the stall
            @(negedge gty_tx_usr_clk);
    endtask

    task automatic send_pair(input stim_t s, input string name);
        if (n_sent < N_PAIRS) begin         // Trailing idles are not recorded
            exp_arr[n_sent].hdr = s.hdr;
            exp_arr[n_sent].blk = s.blk;
            exp_name[n_sent]    = name;
            n_sent              = n_sent + 1;
        end
        put_word(s.txd0, s.txc0);
        put_word(s.txd1, s.txc1);
    endtask

    // Random idle or data pair between table entries
    task automatic send_filler();
        stim_t       s;
        logic [31:0] r;
        r = $random(seed);
        if (r[0]) begin
            send_pair(tbl[0], "filler idle");
        end else begin
            s.txd0 = $random(seed);
            s.txd1 = $random(seed);
            s.txc0 = 4'h0;
            s.txc1 = 4'h0;
            s.hdr  = HDR_DATA;
            s.blk  = {s.txd1, s.txd0};      // Lane 0 lands in bits 7..0
            s.err  = 1'b0;
            send_pair(s, "filler data");
        end
    endtask

    // Take 66 line bits, descramble and compare with the next expected block
    task automatic check_block();
        sync_hdr_t   hdr;
        logic [63:0] blk;
        bit          sb;
        bit          junk;
        logic        ok;
        hdr = {bit_q[1], bit_q[0]};         // Header bit 0 goes out first
        for (int i = 0; i < 64; i++) begin
            sb     = bit_q[i + 2];
            blk[i] = sb ^ dscr_q[38] ^ dscr_q[57];  // x^58 + x^39 + 1
            dscr_q = {dscr_q[56:0], sb};
        end
        for (int i = 0; i < 66; i++)
            junk = bit_q.pop_front();
        if (n_blocks >= n_sent) begin
            $display("Output block %0d appeared with no input pair behind it", n_blocks);
            blk_fail = blk_fail + 1;
        end else begin
            ok = 1'b1;
            if (hdr !== exp_arr[n_blocks].hdr) begin
                $display("MISMATCH at %0t: block %0d (%s) header %b, expected %b", $time,
                         n_blocks, exp_name[n_blocks], hdr, exp_arr[n_blocks].hdr);
                ok = 1'b0;
            end
            if (blk !== exp_arr[n_blocks].blk) begin
                $display("MISMATCH at %0t: block %0d (%s) payload %h, expected %h", $time,
                         n_blocks, exp_name[n_blocks], blk, exp_arr[n_blocks].blk);
                ok = 1'b0;
            end
            if (ok) begin
                blk_pass = blk_pass + 1;
                $display("PASS  block %0d  %s", n_blocks, exp_name[n_blocks]);
            end else begin
                blk_fail = blk_fail + 1;
                $display("FAIL  block %0d  %s", n_blocks, exp_name[n_blocks]);
            end
        end
        n_blocks = n_blocks + 1;
        if (n_blocks == N_PAIRS)
            mon_done = 1'b1;
    endtask

    // Output monitor on the falling edge where registered outputs are stable
    always @(negedge gty_tx_usr_clk) begin
        if (arst_n) begin
            mon_cycle = mon_cycle + 1;
            if (enc_err)
                n_err_seen = n_err_seen + 1;
            if (xgmii_pause) begin
                if (n_pause > 0 && mon_cycle - last_pause != 33) begin
                    $display("MISMATCH at %0t: pause after %0d cycles, expected 33", $time,
                             mon_cycle - last_pause);
                    pause_errs = pause_errs + 1;
                end
                last_pause = mon_cycle;
                n_pause    = n_pause + 1;
            end
            if (gbx_valid) begin
                started = 1'b1;
                for (int i = 0; i < 32; i++)
                    bit_q.push_back(gbx_data[i]);   // LSB first on the line
                while (bit_q.size() >= 66 && !mon_done)
                    check_block();
            end else if (started && !mon_done) begin
                $display("Gearbox output valid dropped at %0t after the stream started", $time);
                valid_drops = valid_drops + 1;
            end
        end
    end

    // Run limit from the number of pairs
    always @(posedge gty_tx_usr_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Timeout: the output did not complete within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        int err_exp;
        int chk_pass;
        int chk_fail;
        $timeformat(-9, 0, " ns", 0);
        arst_n      = 1'b0;
        xgmii_txd   = '0;
        xgmii_txc   = '0;
        xgmii_valid = 1'b0;
        seed        = 83824;
        chk_pass    = 0;
        chk_fail    = 0;
        err_exp     = 0;
        load_table();
        for (int t = 0; t < TBL_LEN; t++) begin
            if (tbl[t].err)
                err_exp = err_exp + REPEATS;
        end
        repeat (4) @(posedge gty_tx_usr_clk);
        @(negedge gty_tx_usr_clk);
        arst_n = 1'b1;
        for (int r = 0; r < REPEATS; r++) begin
            for (int t = 0; t < TBL_LEN; t++) begin
                send_pair(tbl[t], tbl_name[t]);
                send_filler();
            end
        end
        while (!mon_done)                   // XGMII stays continuous until drained
            send_pair(tbl[0], "trailing idle");

        if (n_err_seen != err_exp) begin
            $display("MISMATCH at %0t: %0d encoding error pulses, expected %0d", $time,
                     n_err_seen, err_exp);
            chk_fail = chk_fail + 1;
            $display("FAIL  encoding error flag");
        end else begin
            chk_pass = chk_pass + 1;
            $display("PASS  encoding error flag, %0d pulses", n_err_seen);
        end
        if (n_pause < 2)
            $display("Too few pause cycles seen to check the spacing: %0d", n_pause);
        if (n_pause < 2 || pause_errs != 0) begin
            chk_fail = chk_fail + 1;
            $display("FAIL  pause spacing");
        end else begin
            chk_pass = chk_pass + 1;
            $display("PASS  pause spacing, %0d pauses 33 cycles apart", n_pause);
        end
        if (valid_drops != 0) begin
            chk_fail = chk_fail + 1;
            $display("FAIL  continuous gearbox output");
        end else begin
            chk_pass = chk_pass + 1;
            $display("PASS  continuous gearbox output");
        end

        $display("Tests passed: %0d, failed: %0d", blk_pass + chk_pass, blk_fail + chk_fail);
        if (blk_fail + chk_fail == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
pcs_pkg.sv
xgmii_encoder.sv
scrambler.sv
gearbox.sv
pcs.sv
tb_pcs.sv

// ==== Makefile ====
# Verilator build and run of the PCS transmit path

LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_pcs -f tb.f
	./obj_dir/Vtb_pcs | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
